// ==== Bender.yml ====
package:
  name: secv_mtag

export_include_dirs:
  - .

sources:
  - secv_pkg.sv
  - mtag.sv
  - tag_mem.sv
  - mtag_top.sv
  - target: test
    files:
      - tb_mtag.sv

// ==== list.f ====
+incdir+.
secv_pkg.sv
mtag.sv
tag_mem.sv
mtag_top.sv
tb_mtag.sv

// ==== mtag.sv ====
// One operation at a time, operands must hold until fu_rdy_o and a new request waits for idle
`timescale 1ns/100ps
`include "secv_defs.svh"

module mtag (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 fu_ena_i,     // Level, sampled in idle only
    input  secv_pkg::mtag_op_e   fu_op_i,
    input  secv_pkg::xlen_t      fu_src1_i,    // Pointer with encoded tag
    input  secv_pkg::xlen_t      fu_src2_i,    // Tag for tadr
    output logic                 fu_rdy_o,     // One-cycle pulse
    output logic                 fu_err_o,     // Valid with fu_rdy_o
    output secv_pkg::xlen_t      fu_res_o,     // Valid with fu_rdy_o
    output logic                 tmem_cyc_o,
    output logic                 tmem_stb_o,
    output secv_pkg::tsel_t      tmem_sel_o,
    output secv_pkg::tadr_t      tmem_adr_o,
    output logic                 tmem_we_o,
    output secv_pkg::tag_t       tmem_dat_o,
    input  logic                 tmem_ack_i,
    input  secv_pkg::tag_t       tmem_dat_i
);

    //////////////////////////////
    // Operand decode
    //////////////////////////////

    logic [`SECV_ADR_WIDTH-1:0] mem_adr;       // Used pointer bits
    secv_pkg::tag_t             enc_tag;       // Tag carried in the pointer
    secv_pkg::tag_t             reg_tag;       // Tag from operand 2
    secv_pkg::tadr_t            gran_adr;      // Granule index
    logic                       op_vld;        // Captured opcode is defined

    secv_pkg::mtag_state_e state_q;
    secv_pkg::mtag_op_e    op_q;
    logic                  cyc_q;
    logic                  stb_q;
    logic                  we_q;
    secv_pkg::tsel_t       sel_q;
    logic                  err_q;
    secv_pkg::xlen_t       res_q;
    secv_pkg::tadr_t       adr_q;              // Payload, no reset
    secv_pkg::tag_t        tdat_q;             // Write or compare tag

    assign mem_adr  = fu_src1_i[`SECV_ADR_WIDTH-1:0];
    assign enc_tag  = fu_src1_i[`SECV_XLEN-1 -: `SECV_TLEN];  // Top TLEN bits
    assign reg_tag  = fu_src2_i[`SECV_TLEN-1:0];
    assign gran_adr = secv_pkg::tadr_t'(mem_adr / `SECV_GRANULARITY);

    assign op_vld = op_q inside {secv_pkg::MTAG_OP_TADR, secv_pkg::MTAG_OP_TADRE,
                                 secv_pkg::MTAG_OP_TCHK};

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= secv_pkg::MTAG_IDLE;
            op_q    <= secv_pkg::MTAG_OP_TADR;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            we_q    <= 1'b0;
            sel_q   <= '0;
            err_q   <= 1'b0;
            res_q   <= '0;
        end else begin
            case (state_q)
                secv_pkg::MTAG_IDLE: begin
                    if (fu_ena_i) begin
                        op_q    <= fu_op_i;          // Hold opcode for the bus phase
                        err_q   <= 1'b0;             // Clear previous response
                        res_q   <= '0;
                        state_q <= secv_pkg::MTAG_BUS;
                    end
                end
                secv_pkg::MTAG_BUS: begin
                    if (!op_vld) begin
                        err_q   <= 1'b1;             // Undefined opcode, no bus cycle
                        state_q <= secv_pkg::MTAG_RESP;
                    end else if (!stb_q) begin
                        cyc_q <= 1'b1;               // Open the cycle
                        stb_q <= 1'b1;
                        sel_q <= '1;                 // Whole tag on every access
                        we_q  <= (op_q != secv_pkg::MTAG_OP_TCHK);
                    end else if (tmem_ack_i) begin
                        cyc_q <= 1'b0;
                        stb_q <= 1'b0;
                        sel_q <= '0;
                        we_q  <= 1'b0;
                        if (op_q == secv_pkg::MTAG_OP_TCHK) begin
                            res_q <= secv_pkg::xlen_t'(tmem_dat_i);  // Zero-extended
                            err_q <= (tmem_dat_i != tdat_q);         // Tag mismatch
                        end
                        state_q <= secv_pkg::MTAG_RESP;
                    end
                end
                secv_pkg::MTAG_RESP: begin
                    state_q <= secv_pkg::MTAG_IDLE;  // Ready lasts one cycle
                end
                default: begin
                    state_q <= secv_pkg::MTAG_IDLE;
                end
            endcase
        end
    end

    // Address and tag are captured once per operation
    always_ff @(posedge clk_i) begin
        if (state_q == secv_pkg::MTAG_IDLE && fu_ena_i) begin
            adr_q  <= gran_adr;
            tdat_q <= (fu_op_i == secv_pkg::MTAG_OP_TADR) ? reg_tag : enc_tag;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign fu_rdy_o   = (state_q == secv_pkg::MTAG_RESP);
    assign fu_err_o   = err_q;
    assign fu_res_o   = res_q;
    assign tmem_cyc_o = cyc_q;
    assign tmem_stb_o = stb_q;
    assign tmem_sel_o = sel_q;
    assign tmem_adr_o = adr_q;
    assign tmem_we_o  = we_q;
    assign tmem_dat_o = tdat_q;

    //////////////////////////////
    // Assertions
    //////////////////////////////

    a_stb_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmem_stb_o |-> tmem_cyc_o)
        else $error("mtag: stb without cyc");

    a_ack_stb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmem_ack_i |-> tmem_stb_o)                  // Slave answers only open strobes
        else $error("mtag: ack without stb");

    a_rdy_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fu_rdy_o |=> !fu_rdy_o)
        else $error("mtag: rdy longer than one cycle");

endmodule

// ==== mtag_top.sv ====
// Function unit and its private tag memory, the core side keeps operands stable until fu_rdy_o
`timescale 1ns/100ps

module mtag_top (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               fu_ena_i,
    input  secv_pkg::mtag_op_e fu_op_i,
    input  secv_pkg::xlen_t    fu_src1_i,
    input  secv_pkg::xlen_t    fu_src2_i,
    output logic               fu_rdy_o,
    output logic               fu_err_o,
    output secv_pkg::xlen_t    fu_res_o
);

    //////////////////////////////
    // Tag bus
    //////////////////////////////

    logic            tmem_cyc;
    logic            tmem_stb;
    secv_pkg::tsel_t tmem_sel;
    secv_pkg::tadr_t tmem_adr;
    logic            tmem_we;
    secv_pkg::tag_t  tmem_dat_w;    // Master to slave
    secv_pkg::tag_t  tmem_dat_r;    // Slave to master
    logic            tmem_ack;

    mtag u_mtag (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .fu_ena_i   (fu_ena_i),
        .fu_op_i    (fu_op_i),
        .fu_src1_i  (fu_src1_i),
        .fu_src2_i  (fu_src2_i),
        .fu_rdy_o   (fu_rdy_o),
        .fu_err_o   (fu_err_o),
        .fu_res_o   (fu_res_o),
        .tmem_cyc_o (tmem_cyc),
        .tmem_stb_o (tmem_stb),
        .tmem_sel_o (tmem_sel),
        .tmem_adr_o (tmem_adr),
        .tmem_we_o  (tmem_we),
        .tmem_dat_o (tmem_dat_w),
        .tmem_ack_i (tmem_ack),
        .tmem_dat_i (tmem_dat_r)
    );

    tag_mem u_tag_mem (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .tmem_cyc_i (tmem_cyc),
        .tmem_stb_i (tmem_stb),
        .tmem_we_i  (tmem_we),
        .tmem_sel_i (tmem_sel),
        .tmem_adr_i (tmem_adr),
        .tmem_dat_i (tmem_dat_w),
        .tmem_ack_o (tmem_ack),
        .tmem_dat_o (tmem_dat_r)
    );

endmodule

// ==== secv_defs.svh ====
// Sizes are fixed for one build and the tag memory only covers the low 2**ADR_WIDTH bytes
`ifndef SECV_DEFS_SVH
`define SECV_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

`define SECV_XLEN 32                // Operand and result width
`define SECV_TLEN 16                // Tag width, whole bytes only

//////////////////////////////
// Tag memory geometry
//////////////////////////////

`define SECV_GRANULARITY 8          // Bytes per granule, power of two

`define SECV_ADR_WIDTH 8            // Low pointer bits that select a granule

`define SECV_TADR_WIDTH 5           // 256 bytes / 8 per granule = 32 tags

`define SECV_TAG_DEPTH (1 << `SECV_TADR_WIDTH)  // Number of stored tags

`define SECV_TSEL_WIDTH (`SECV_TLEN / 8)  // One select per tag byte

//////////////////////////////
// Operation encoding
//////////////////////////////

`define SECV_OP_WIDTH 3             // Room for five undefined opcodes

`endif

// ==== secv_pkg.sv ====
// Types only, all widths come from the shared header and opcodes 3 to 7 stay undefined
`include "secv_defs.svh"

package secv_pkg;

    //////////////////////////////
    // Vector types
    //////////////////////////////

    typedef logic [`SECV_XLEN-1:0]       xlen_t;  // Operand and result word
    typedef logic [`SECV_TLEN-1:0]       tag_t;   // One granule tag
    typedef logic [`SECV_TADR_WIDTH-1:0] tadr_t;  // Tag memory word address
    typedef logic [`SECV_TSEL_WIDTH-1:0] tsel_t;  // Tag bus byte lanes

    //////////////////////////////
    // Function unit opcodes
    //////////////////////////////

    typedef enum logic [`SECV_OP_WIDTH-1:0] {
        MTAG_OP_TADR  = 3'd0,           // Tag from operand 2
        MTAG_OP_TADRE = 3'd1,           // Tag from pointer top bits
        MTAG_OP_TCHK  = 3'd2            // Read and compare
    } mtag_op_e;

    //////////////////////////////
    // Function unit FSM
    //////////////////////////////

    typedef enum logic [1:0] {
        MTAG_IDLE = 2'd0,               // Waiting for fu_ena_i
        MTAG_BUS  = 2'd1,               // Tag bus cycle in flight
        MTAG_RESP = 2'd2                // Ready pulse
    } mtag_state_e;

endpackage

// ==== tag_mem.sv ====
// Single-port tag store with one registered ack per strobe, all tags read zero after reset
`timescale 1ns/100ps
`include "secv_defs.svh"

module tag_mem (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             tmem_cyc_i,
    input  logic             tmem_stb_i,
    input  logic             tmem_we_i,
    input  secv_pkg::tsel_t  tmem_sel_i,    // Byte lanes for writes
    input  secv_pkg::tadr_t  tmem_adr_i,    // Granule index
    input  secv_pkg::tag_t   tmem_dat_i,    // Write tag
    output logic             tmem_ack_o,    // One-cycle pulse
    output secv_pkg::tag_t   tmem_dat_o     // Read tag, valid with ack
);

    //////////////////////////////
    // Storage and handshake
    //////////////////////////////

    secv_pkg::tag_t tags_q [`SECV_TAG_DEPTH];  // One tag per granule
    logic           req;                       // Strobe not yet answered
    logic           ack_q;
    secv_pkg::tag_t dat_q;

    // Ack pending blocks a second answer to the same strobe
    assign req = tmem_cyc_i & tmem_stb_i & ~ack_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            for (int i = 0; i < `SECV_TAG_DEPTH; i++) begin
                tags_q[i] <= '0;               // Untagged memory starts at zero
            end
        end else begin
            ack_q <= req;                      // Answer one clock after the strobe
            if (req && tmem_we_i) begin
                for (int b = 0; b < `SECV_TSEL_WIDTH; b++) begin
                    if (tmem_sel_i[b]) begin
                        tags_q[tmem_adr_i][8*b +: 8] <= tmem_dat_i[8*b +: 8];  // Lane write
                    end
                end
            end
        end
    end

    // Registered read, lines up with ack
    always_ff @(posedge clk_i) begin
        if (req && !tmem_we_i) begin
            dat_q <= tags_q[tmem_adr_i];
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    assign tmem_ack_o = ack_q;
    assign tmem_dat_o = dat_q;

    //////////////////////////////
    // Assertions
    //////////////////////////////

    a_adr_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmem_stb_i |-> !$isunknown(tmem_adr_i))
        else $error("tag_mem: unknown address during stb");

endmodule

// ==== tb_mtag.sv ====
// Random check against a tag model, one operation in flight and operands held until fu_rdy_o
`timescale 1ns/100ps

module tb_mtag;

    //////////////////////////////
    // Run length
    //////////////////////////////

    localparam int N_SWEEP        = 32;             // One tchk per granule after reset
    localparam int N_ALIAS        = 8;              // Two ops each
    localparam int N_TADRE        = 8;              // Three ops each
    localparam int N_UNDEF        = 4;              // Two ops each
    localparam int N_RANDOM       = 400;
    localparam int N_OPS          = N_SWEEP + 2*N_ALIAS + 3*N_TADRE + 2*N_UNDEF + N_RANDOM;
    localparam int OP_CYCLES      = 5;              // Sample, strobe, ack, ready, back to idle
    localparam int OP_WAIT_LIMIT  = 16;             // Per operation
    localparam int IDLE_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES = N_OPS * (OP_CYCLES + 1) + IDLE_CYCLES + 64;

    //////////////////////////////
    // DUT signals
    //////////////////////////////

    logic               clk;
    logic               arst_n;
    logic               fu_ena;
    secv_pkg::mtag_op_e fu_op;
    secv_pkg::xlen_t    fu_src1;
    secv_pkg::xlen_t    fu_src2;
    logic               fu_rdy;
    logic               fu_err;
    secv_pkg::xlen_t    fu_res;

    logic [15:0] model_tags [32];                   // Expected tag per granule
    logic [31:0] rng_state;
    int          mismatch_cnt;
    int          timeout_cnt;
    int          op_cnt;
    int          cycle_cnt;

    mtag_top dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .fu_ena_i  (fu_ena),
        .fu_op_i   (fu_op),
        .fu_src1_i (fu_src1),
        .fu_src2_i (fu_src2),
        .fu_rdy_o  (fu_rdy),
        .fu_err_o  (fu_err),
        .fu_res_o  (fu_res)
    );

    always #5 clk = ~clk;                           // 10 ns period

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // No operation issued, so ready must stay low
    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            assert (fu_rdy === 1'b0) else begin
                mismatch_cnt++;
                $display("Mismatch idle_rdy cycle %0d: expected 0, actual %b", i, fu_rdy);
            end
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after an edge with the unit idle
    task automatic run_op(input string name, input logic [2:0] op,
                          input logic [31:0] src1, input logic [31:0] src2);
        logic [4:0]  gran;
        logic [31:0] exp_res;
        logic        exp_err;
        int          waited;
        gran    = 5'(src1[7:0] / 8);                // Granule of the pointer
        exp_res = '0;
        exp_err = 1'b0;
        case (op)
            3'd0: model_tags[gran] = src2[15:0];    // tadr
            3'd1: model_tags[gran] = src1[31:16];   // tadre
            3'd2: begin                             // tchk
                exp_res = {16'h0, model_tags[gran]};
                exp_err = (model_tags[gran] != src1[31:16]);
            end
            default: exp_err = 1'b1;                // Undefined opcode
        endcase
        fu_ena  = 1'b1;
        fu_op   = secv_pkg::mtag_op_e'(op);
        fu_src1 = src1;
        fu_src2 = src2;
        op_cnt++;
        waited  = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!fu_rdy && waited < OP_WAIT_LIMIT);
        fu_ena = 1'b0;
        assert (fu_rdy === 1'b1) else begin
            timeout_cnt++;
            $display("Timeout: %s op %0d got no ready within %0d cycles",
                     name, op_cnt, OP_WAIT_LIMIT);
        end
        if (fu_rdy === 1'b1) begin
            assert (fu_err === exp_err) else begin
                mismatch_cnt++;
                $display("Mismatch %s op %0d err: expected %b, actual %b",
                         name, op_cnt, exp_err, fu_err);
            end
            assert (fu_res === exp_res) else begin
                mismatch_cnt++;
                $display("Mismatch %s op %0d res: expected %h, actual %h",
                         name, op_cnt, exp_res, fu_res);
            end
            @(posedge clk);
            #1;
            assert (fu_rdy === 1'b0) else begin     // Ready is a single pulse
                mismatch_cnt++;
                $display("Mismatch %s op %0d rdy pulse: expected 0, actual %b",
                         name, op_cnt, fu_rdy);
            end
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] p;
        logic [31:0] src1;
        logic [4:0]  g;
        logic [15:0] t;
        logic [15:0] u;
        logic [2:0]  op;
        clk          = 1'b0;
        arst_n       = 1'b0;
        fu_ena       = 1'b0;
        fu_op        = secv_pkg::MTAG_OP_TADR;
        fu_src1      = '0;
        fu_src2      = '0;
        rng_state    = 32'h1671720d;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        op_cnt       = 0;
        for (int i = 0; i < 32; i++) begin
            model_tags[i] = '0;                     // Memory is clear after reset
        end
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        check_idle(IDLE_CYCLES);
        for (int i = 0; i < N_SWEEP; i++) begin     // Every granule reads zero
            r = next_rand();
            run_op("reset_sweep", 3'd2, {16'h0, r[15:8], 5'(i), r[2:0]}, r);
        end

        for (int i = 0; i < N_ALIAS; i++) begin     // Other byte of the same granule
            r = next_rand();
            s = next_rand();
            g = r[4:0];
            t = r[31:16];
            run_op("tadr_alias", 3'd0, {s[31:8], g, s[2:0]}, {s[15:0], t});
            run_op("tadr_alias", 3'd2, {t, s[15:8], g, ~s[2:0]}, 32'h0);
        end

        for (int i = 0; i < N_TADRE; i++) begin
            r = next_rand();
            s = next_rand();
            g = r[4:0];
            t = r[31:16];
            u = s[31:16] | 16'h1;                   // Never zero, tag always differs
            run_op("tadre_store", 3'd1, {t, s[15:8], g, s[2:0]}, s);
            run_op("tadre_match", 3'd2, {t, r[15:8], g, r[7:5]}, 32'h0);
            run_op("tadre_other", 3'd2, {t ^ u, r[15:8], g, s[2:0]}, 32'h0);
        end

        for (int i = 0; i < N_UNDEF; i++) begin     // Opcodes 3 to 7
            r  = next_rand();
            s  = next_rand();
            g  = r[4:0];
            op = 3'd3 + 3'(s[7:0] % 5);
            run_op("undef_op", op, {r[31:8], g, r[2:0]}, s);
            run_op("undef_after", 3'd2, {model_tags[g], s[15:8], g, s[2:0]}, 32'h0);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            r    = next_rand();
            s    = next_rand();
            p    = next_rand();
            src1 = s;
            if (r[3:0] < 4'd5) begin
                op = 3'd0;
            end else if (r[3:0] < 4'd10) begin
                op = 3'd1;
            end else if (r[3:0] < 4'd15) begin
                op = 3'd2;
            end else begin
                op = 3'd3 + 3'(r[7:4] % 5);         // Rare undefined opcode
            end
            if (op == 3'd2 && r[8]) begin
                src1[31:16] = model_tags[s[7:3]];   // Half the checks should match
            end
            run_op("random_mix", op, src1, p);
        end

        $display("Errors: %0d mismatches, %0d timeouts in %0d operations",
                 mismatch_cnt, timeout_cnt, op_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Errors: %0d mismatches, %0d timeouts in %0d operations",
                 mismatch_cnt, timeout_cnt + 1, op_cnt);
        $display("** FAIL **");
        $finish;
    end

endmodule
